/* hdl/stick_consts.svh */
`ifndef STICK_CONSTS_SVH
`define STICK_CONSTS_SVH

// ------------------------------
// channel layout
// ------------------------------
`define STICK_PHY_CH        4    // physical zond channels
`define STICK_VIRT_PER_PHY  4    // virtual channels behind each physical one

// ------------------------------
// command word
// ------------------------------
`define STICK_CMD_W         32
`define STICK_OP_SYNC       5'h10 // internal sync on/off, value bit 0
`define STICK_OP_HV         5'h11 // hv code 2:0, power-down mask 6:3

// master sync period in sysclk cycles
// must stay above largest delay + width + 2
`define STICK_SYNC_PERIOD   64

`endif

/* hdl/stick_pkg.sv */
`default_nettype none

`include "stick_consts.svh"

package stick_pkg;

	// command word, two formats
	// [31]=1 : system cmd, [30:26] opcode, low bits value
	// [31]=0 : param write, [30] 0=width 1=delay, [29:26] channel, [7:0] value
	typedef logic [`STICK_CMD_W-1:0] cmd_word_t;

	// pulse width in cycles, zero means no pulse
	typedef logic [7:0] pulse_w_t;

	// delay from master sync to probe pulse
	typedef logic [7:0] znd_delay_t;

	// high voltage code
	// 111 -> 90 V, 011 -> 60 V, 001 -> 30 V, 000 -> off
	typedef logic [2:0] hv_level_t;

	typedef logic [1:0] vch_sel_t; // virtual channel index inside a zond

	typedef logic [`STICK_PHY_CH-1:0] chan_mask_t; // one bit per physical channel

endpackage

`default_nettype wire

/* hdl/chan_cfg_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

// pulse setup of one physical channel, bank -> zond
interface chan_cfg_if;
	import stick_pkg::*;

	pulse_w_t   pulse_w [`STICK_VIRT_PER_PHY]; // widths of the four virtual channels
	znd_delay_t delay;                         // sync to pulse delay, shared by all four

	// bank side, levels move only on a write
	modport bank_mp (output pulse_w, output delay);

	// zond side
	modport znd_mp (input pulse_w, input delay);

endinterface

`default_nettype wire

/* hdl/cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module cmd_decode (
	input  wire                   sysclk,
	input  wire                   phy_rst_n,
	input  stick_pkg::cmd_word_t  i_cmd,
	input  wire                   i_cmd_valid,
	output logic                  o_sync_on,   // internal master sync enable
	output stick_pkg::hv_level_t  o_hpwon,     // high voltage code
	output stick_pkg::chan_mask_t o_pdwn,      // per channel power-down
	output logic                  o_par_wr,    // one cycle write strobe to bank
	output logic                  o_par_sel,   // 0 width, 1 delay
	output logic [3:0]            o_par_addr,
	output logic [7:0]            o_par_val
);

	// ------------------------------
	// board settings
	// ------------------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
		begin
			o_sync_on <= 1'b0;
			o_hpwon   <= 3'b000; // hv off
			o_pdwn    <= '0;
		end
		else if (i_cmd_valid && i_cmd[31])
		begin
			case (i_cmd[30:26])
				`STICK_OP_SYNC : o_sync_on <= i_cmd[0];
				`STICK_OP_HV :
				begin
					o_hpwon <= i_cmd[2:0];
					o_pdwn  <= i_cmd[6:3];
				end
				default : ; // unknown opcode, nothing happens
			endcase
		end
	end

	// ------------------------------
	// parameter writes
	// ------------------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			o_par_wr <= 1'b0;
		else
			o_par_wr <= i_cmd_valid & ~i_cmd[31]; // every param word is taken
	end

	// address and value, only looked at with o_par_wr
	always_ff @(posedge sysclk)
	begin
		if (i_cmd_valid && !i_cmd[31])
		begin
			o_par_sel  <= i_cmd[30];
			o_par_addr <= i_cmd[29:26]; // virtual ch, or phys ch in 27:26
			o_par_val  <= i_cmd[7:0];
		end
	end

endmodule

`default_nettype wire

/* hdl/param_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module param_bank (
	input  wire        sysclk,
	input  wire        phy_rst_n,
	input  wire        i_par_wr,
	input  wire        i_par_sel,   // 0 width, 1 delay
	input  wire  [3:0] i_par_addr,
	input  wire  [7:0] i_par_val,
	chan_cfg_if.bank_mp cfg [`STICK_PHY_CH]
);
	import stick_pkg::*;

	localparam int N_VIRT = `STICK_PHY_CH * `STICK_VIRT_PER_PHY;

	pulse_w_t   width_q [N_VIRT];        // virtual channel widths, 0..15
	znd_delay_t delay_q [`STICK_PHY_CH]; // one delay per physical channel

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
		begin
			for (int i = 0; i < N_VIRT; i++)
				width_q[i] <= '0;
			for (int j = 0; j < `STICK_PHY_CH; j++)
				delay_q[j] <= '0;
		end
		else if (i_par_wr)
		begin
			if (i_par_sel)
				delay_q[i_par_addr[1:0]] <= i_par_val; // upper addr bits ignored
			else
				width_q[i_par_addr] <= i_par_val;
		end
	end

	// ------------------------------
	// fan out per physical channel
	// ------------------------------
	for (genvar g = 0; g < `STICK_PHY_CH; g++)
	begin : g_phy
		assign cfg[g].delay = delay_q[g];
		// virtual ch v of zond g sits at g*4+v
		for (genvar v = 0; v < `STICK_VIRT_PER_PHY; v++)
		begin : g_virt
			assign cfg[g].pulse_w[v] = width_q[g*`STICK_VIRT_PER_PHY + v];
		end
	end

endmodule

`default_nettype wire

/* hdl/msync_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module msync_gen (
	input  wire  sysclk,
	input  wire  phy_rst_n,
	input  wire  i_sync_on,
	output logic o_msync,   // one cycle strobe, active high
	output logic o_msync_n  // board sync line
);

	localparam int CNT_W = $clog2(`STICK_SYNC_PERIOD + 1);
	localparam logic [CNT_W-1:0] PERIOD = CNT_W'(`STICK_SYNC_PERIOD);

	logic [CNT_W-1:0] cnt; // 0 while off, then runs 1..PERIOD

	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
			cnt <= '0;
		else if (!i_sync_on)
			cnt <= '0;           // held while disabled
		else if (cnt == PERIOD)
			cnt <= CNT_W'(1);    // wrap, keeps spacing at PERIOD
		else
			cnt <= cnt + CNT_W'(1);
	end

	// qualified by enable so a disable kills the strobe right away
	assign o_msync   = i_sync_on & (cnt == PERIOD);
	assign o_msync_n = ~o_msync;

endmodule

`default_nettype wire

/* hdl/znd_pulse.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module znd_pulse (
	input  wire                            sysclk,
	input  wire                            phy_rst_n,
	input  wire                            i_msync,  // master sync strobe
	input  wire                            i_pdwn,   // channel powered down
	chan_cfg_if.znd_mp                     cfg,
	output logic                           o_imp_a,  // probe pulse
	output logic [`STICK_VIRT_PER_PHY-1:0] o_enz_n   // low bit = active virtual ch
);
	import stick_pkg::*;

	logic       dly_on;  // counting delay after a sync
	znd_delay_t dcnt;
	logic       imp_q;   // pulse running
	pulse_w_t   wcnt;    // cycles of pulse left
	vch_sel_t   vch;     // current virtual channel
	pulse_w_t   cur_w;
	logic       accept;
	logic       fire;

	// ------------------------------
	// strobe handling
	// ------------------------------
	// busy channels and powered down ones drop the sync
	assign accept = i_msync & ~i_pdwn & ~dly_on & ~imp_q;

	// zero delay fires on the strobe edge itself
	assign fire = (accept & (cfg.delay == '0)) | (dly_on & (dcnt == 8'd1));

	assign cur_w = cfg.pulse_w[vch];

	always_ff @(posedge sysclk or negedge phy_rst_n)
	begin
		if (!phy_rst_n)
		begin
			dly_on <= 1'b0;
			dcnt   <= '0;
			imp_q  <= 1'b0;
			wcnt   <= '0;
			vch    <= '0;
		end
		else
		begin
			// delay counter
			if (accept && cfg.delay != '0)
			begin
				dly_on <= 1'b1;
				dcnt   <= cfg.delay;
			end
			else if (dly_on)
			begin
				dcnt <= dcnt - 8'd1;
				if (dcnt == 8'd1)
					dly_on <= 1'b0; // fire goes out this edge
			end

			// width counter and rotation
			if (fire)
			begin
				if (cur_w != '0)
				begin
					imp_q <= 1'b1;
					wcnt  <= cur_w;
				end
				else
					vch <= vch + 2'd1; // empty slot, still rotate
			end
			else if (imp_q)
			begin
				wcnt <= wcnt - 8'd1;
				if (wcnt == 8'd1)
				begin
					imp_q <= 1'b0;
					vch   <= vch + 2'd1; // next sync goes to next virtual ch
				end
			end
		end
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign o_imp_a = imp_q;

	// enable low only for the firing virtual ch
	assign o_enz_n = imp_q ? ~(`STICK_VIRT_PER_PHY'(1) << vch) : '1;

endmodule

`default_nettype wire

/* hdl/stick_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module stick_top (
	input  wire                   sysclk,
	input  wire                   phy_rst_n,
	// parameter commands
	input  stick_pkg::cmd_word_t  i_cmd,
	input  wire                   i_cmd_valid,
	// zond channels
	output stick_pkg::chan_mask_t o_phase_a,
	output logic [`STICK_PHY_CH-1:0][`STICK_VIRT_PER_PHY-1:0] o_nenz,
	// board lines
	output logic                  o_msync_n,
	output stick_pkg::hv_level_t  o_hpwon,
	output stick_pkg::chan_mask_t o_pdwn
);

	logic       sync_on;   // decoder -> sync gen
	logic       msync;     // sync strobe to all zonds
	logic       par_wr;
	logic       par_sel;
	logic [3:0] par_addr;
	logic [7:0] par_val;

	chan_cfg_if cfg_if [`STICK_PHY_CH] (); // bank -> zond setup, one per channel

	// ------------------------------
	// command path
	// ------------------------------
	cmd_decode u_cmd_decode (
		.sysclk      (sysclk),
		.phy_rst_n   (phy_rst_n),
		.i_cmd       (i_cmd),
		.i_cmd_valid (i_cmd_valid),
		.o_sync_on   (sync_on),
		.o_hpwon     (o_hpwon),
		.o_pdwn      (o_pdwn),
		.o_par_wr    (par_wr),
		.o_par_sel   (par_sel),
		.o_par_addr  (par_addr),
		.o_par_val   (par_val)
	);

	param_bank u_param_bank (
		.sysclk     (sysclk),
		.phy_rst_n  (phy_rst_n),
		.i_par_wr   (par_wr),
		.i_par_sel  (par_sel),
		.i_par_addr (par_addr),
		.i_par_val  (par_val),
		.cfg        (cfg_if)
	);

	// ------------------------------
	// master sync
	// ------------------------------
	msync_gen u_msync_gen (
		.sysclk    (sysclk),
		.phy_rst_n (phy_rst_n),
		.i_sync_on (sync_on),
		.o_msync   (msync),
		.o_msync_n (o_msync_n)
	);

	// ------------------------------
	// zond channels
	// ------------------------------
	for (genvar g = 0; g < `STICK_PHY_CH; g++)
	begin : g_znd
		znd_pulse u_znd (
			.sysclk    (sysclk),
			.phy_rst_n (phy_rst_n),
			.i_msync   (msync),
			.i_pdwn    (o_pdwn[g]),  // sleep bit of this channel
			.cfg       (cfg_if[g]),
			.o_imp_a   (o_phase_a[g]),
			.o_enz_n   (o_nenz[g])
		);
	end

endmodule

`default_nettype wire

/* bench/stick_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module stick_chk (
	input wire                         sysclk,
	input wire                         phy_rst_n,
	input wire                         i_cmd_valid,
	input wire stick_pkg::chan_mask_t  o_phase_a,
	input wire [`STICK_PHY_CH-1:0][`STICK_VIRT_PER_PHY-1:0] o_nenz,
	input wire                         o_msync_n,
	input wire stick_pkg::hv_level_t   o_hpwon,
	input wire stick_pkg::chan_mask_t  o_pdwn
);

	// ------------------------------
	// sync line
	// ------------------------------
	a_msync_one_cycle : assert property (
		@(posedge sysclk) disable iff (!phy_rst_n)
		!o_msync_n |=> o_msync_n
	) else $error("master sync line low for more than one cycle");

	// enables idle while no probe pulse
	for (genvar g = 0; g < `STICK_PHY_CH; g++)
	begin : g_enz
		a_enz_idle : assert property (
			@(posedge sysclk) disable iff (!phy_rst_n)
			!o_phase_a[g] |-> (o_nenz[g] == '1)
		) else $error("enable of channel %0d low without a probe pulse", g);
	end

	// settings move only after a strobe driven two edges back
	a_settings_hold : assert property (
		@(posedge sysclk) disable iff (!phy_rst_n)
		!$past(i_cmd_valid) |-> $stable({o_hpwon, o_pdwn})
	) else $error("hv code or power-down mask changed without a command");

endmodule

bind stick_top stick_chk u_chk (
	.sysclk      (sysclk),
	.phy_rst_n   (phy_rst_n),
	.i_cmd_valid (i_cmd_valid),
	.o_phase_a   (o_phase_a),
	.o_nenz      (o_nenz),
	.o_msync_n   (o_msync_n),
	.o_hpwon     (o_hpwon),
	.o_pdwn      (o_pdwn)
);

`default_nettype wire

/* bench/tb_stick.sv */
`timescale 1ns/1ns
`default_nettype none

`include "stick_consts.svh"

module tb_stick;
	import stick_pkg::*;

	localparam int    PERIOD   = `STICK_SYNC_PERIOD;
	localparam int    WINDOW   = PERIOD / 2; // every pulse is over by then
	localparam string PAT_FILE = "bench/stick_patterns.txt";

	logic       sysclk;
	logic       phy_rst_n;
	cmd_word_t  i_cmd;
	logic       i_cmd_valid;
	chan_mask_t o_phase_a;
	logic [`STICK_PHY_CH-1:0][`STICK_VIRT_PER_PHY-1:0] o_nenz;
	logic       o_msync_n;
	hv_level_t  o_hpwon;
	chan_mask_t o_pdwn;

	int     n_mismatch = 0;
	int     n_fail     = 0;
	int     wd_cycles  = 0;     // known once the pattern file is sized
	integer seed       = 74380;
	string  tname      = "reset";

	stick_top DUT (.*);

	initial
	begin
		sysclk = 1'b0;
		forever #10 sysclk = ~sysclk; // 20 ns
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic note_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("mismatch %s %s: expected 0x%0h, actual 0x%0h", tname, what, exp, act);
		n_mismatch++;
	endtask

	task automatic check_width(input string what, input pulse_w_t exp, input pulse_w_t act);
		if (act !== exp)
			note_mismatch(what, exp, act);
	endtask

	task automatic check_delay(input string what, input znd_delay_t exp, input znd_delay_t act);
		if (act !== exp)
			note_mismatch(what, exp, act);
	endtask

	task automatic check_hv(input string what, input hv_level_t exp, input hv_level_t act);
		if (act !== exp)
			note_mismatch(what, exp, act);
	endtask

	task automatic check_mask(input string what, input chan_mask_t exp, input chan_mask_t act);
		if (act !== exp)
			note_mismatch(what, exp, act);
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp)
			note_mismatch(what, exp, act);
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", tname, what);
		n_fail++;
	endtask

	// ------------------------------
	// stimulus and measurement
	// ------------------------------
	task automatic send_cmd(input cmd_word_t w);
		@(posedge sysclk);
		i_cmd       <= w;
		i_cmd_valid <= 1'b1;
		@(posedge sysclk); // decoder takes the word on this edge
		i_cmd_valid <= 1'b0;
	endtask

	// rising edges from here to the cycle with the sync line low
	task automatic edges_to_sync(output int n);
		n = 0;
		do
		begin
			@(posedge sysclk);
			n++;
			@(negedge sysclk);
		end
		while (o_msync_n !== 1'b0 && n < 2 * PERIOD);
	endtask

	task automatic check_pulse(input int phy, input vch_sel_t vch, input znd_delay_t exp_d,
		input pulse_w_t exp_w);
		int         n_sync;
		int         rise;
		pulse_w_t   w;
		chan_mask_t exp_enz;
		rise    = -1;
		w       = '0;
		exp_enz = '1;
		exp_enz[vch] = 1'b0; // only the active vch enabled
		edges_to_sync(n_sync);
		if (o_msync_n !== 1'b0)
			report_failure("no master sync came");
		for (int n = 1; n <= WINDOW; n++)
		begin
			@(negedge sysclk);
			if (o_phase_a[phy] === 1'b1)
			begin
				if (rise < 0)
					rise = n;
				w++;
				check_mask("nenz", exp_enz, o_nenz[phy]);
			end
		end
		if (exp_w != '0 && rise < 0)
			report_failure($sformatf("no probe pulse on channel %0d", phy));
		else
		begin
			if (exp_w != '0)
				check_delay("delay", exp_d, znd_delay_t'(rise - 1)); // rise is delay+1 after sync
			check_width("width", exp_w, w);
		end
	endtask

	task automatic check_quiet();
		bit noisy;
		noisy = 1'b0;
		repeat (2 * PERIOD)
		begin
			@(negedge sysclk);
			if (o_msync_n !== 1'b1 || o_phase_a !== '0)
				noisy = 1'b1;
		end
		if (noisy)
			report_failure("sync or probe pulse seen while the sync is off");
	endtask

	task automatic count_p_lines(output int n);
		int    fd;
		int    r;
		string tok;
		string rest;
		n  = 0;
		fd = $fopen(PAT_FILE, "r");
		if (fd != 0)
		begin
			while ($fscanf(fd, "%s", tok) == 1)
			begin
				if (tok[0] == "#")
					r = $fgets(rest, fd); // comment line
				else if (tok == "P")
					n++;
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial
	begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge sysclk);
		$display("timeout: patterns not done after %0d cycles", wd_cycles);
		$display("Finished with errors");
		$finish;
	end

	// ------------------------------
	// pattern runner
	// ------------------------------
	initial
	begin
		int          fd;
		int          r;
		int          n_p;
		int          item;
		int          gap;
		int          n_edges;
		string       tok;
		string       rest;
		cmd_word_t   word;
		logic [31:0] a, b, c, d;

		phy_rst_n   = 1'b0;
		i_cmd       = '0;
		i_cmd_valid = 1'b0;
		item        = 0;
		count_p_lines(n_p);
		wd_cycles = (n_p + 4) * PERIOD * 4;
		repeat (2) @(posedge sysclk);
		phy_rst_n <= 1'b1;
		@(negedge sysclk);
		check_mask("phase_a", '0, o_phase_a);
		for (int g = 0; g < `STICK_PHY_CH; g++)
			check_mask($sformatf("nenz%0d", g), '1, o_nenz[g]);

		fd = $fopen(PAT_FILE, "r");
		if (fd == 0)
			report_failure("cannot open the pattern file");
		else
		begin
			while ($fscanf(fd, "%s", tok) == 1)
			begin
				if (tok[0] == "#")
					r = $fgets(rest, fd);
				else
				begin
					item++;
					tname = $sformatf("%s item %0d", tok, item);
					if (tok == "C")
					begin
						r = $fscanf(fd, "%h", word);
						if (r != 1)
							report_failure("command line has no word");
						else
						begin
							gap = $unsigned($random(seed)) % 4; // idle 0..3 cycles
							repeat (gap) @(posedge sysclk);
							send_cmd(word);
						end
					end
					else if (tok == "H")
					begin
						r = $fscanf(fd, "%h %h", a, b);
						if (r != 2)
							report_failure("settings line needs two values");
						else
						begin
							@(negedge sysclk);
							check_hv("hpwon", hv_level_t'(a), o_hpwon);
							check_mask("pdwn", chan_mask_t'(b), o_pdwn);
						end
					end
					else if (tok == "S")
					begin
						edges_to_sync(n_edges); // first sync after the enable edge
						check_count("first sync", PERIOD, n_edges);
						edges_to_sync(n_edges);
						check_count("sync spacing", PERIOD, n_edges);
					end
					else if (tok == "P")
					begin
						r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
						if (r != 4)
							report_failure("pulse line needs four values");
						else
							check_pulse(a, vch_sel_t'(b), znd_delay_t'(c), pulse_w_t'(d));
					end
					else if (tok == "Q")
						check_quiet();
					else
						report_failure("unknown line in the pattern file");
				end
			end
			$fclose(fd);
		end

		$display("error count: %0d mismatches, %0d other failures", n_mismatch, n_fail);
		if (n_mismatch + n_fail == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/stick_patterns.txt */
# C word : send command | H hpwon pdwn : expect settings | S : sync timing after last C
# P phy vch delay width : expect pulse at next sync | Q : expect silence | numbers in hex
H 0 0
Q
C fc00007f
H 0 0
C c4000003
H 3 0
C 00000003
C 04000005
C 0c000002
C 30000004
C 38000009
C 40000005
C 4c000007
C c0000001
S
P 0 2 5 0
P 0 3 5 2
P 0 0 5 3
P 0 1 5 5
C c4000043
H 3 8
P 3 2 7 0
C c4000003
H 3 0
P 3 2 7 9
C c0000000
Q

/* src.f */
+incdir+hdl
hdl/stick_pkg.sv
hdl/chan_cfg_if.sv
hdl/cmd_decode.sv
hdl/param_bank.sv
hdl/msync_gen.sv
hdl/znd_pulse.sv
hdl/stick_top.sv
bench/stick_chk.sv
bench/tb_stick.sv

/* Bender.yml */
package:
  name: stick_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/stick_pkg.sv
      - hdl/chan_cfg_if.sv
      - hdl/cmd_decode.sv
      - hdl/param_bank.sv
      - hdl/msync_gen.sv
      - hdl/znd_pulse.sv
      - hdl/stick_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/stick_chk.sv
      - bench/tb_stick.sv
